// File: robotTests.txt
# enable track(left mid right, or rnd) hold-cycles expected-state
1 010 14 countdown
1 010 50 straight
1 001 20 littleRight
1 100 20 littleLeft
1 rnd 20 straight
1 111 20 choose
1 101 20 stop
1 010 30 left
1 111 20 stop
1 rnd 40 straight
1 000 20 stop
1 000 40 back
1 111 20 stop
1 010 40 left
1 101 20 stop
1 111 40 right
1 101 20 error
0 101 20 idle

// File: flist.f
robotPkg.sv
navFsm.sv
phaseTimer.sv
statusLeds.sv
digitDisplay.sv
motorDrive.sv
robotTop.sv
robotChecker.sv
tb_robotTop.sv

// File: run.sh
#!/bin/sh
verilator --binary --top-module tb_robotTop -f flist.f -o simv > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// File: tb_robotTop.sv
module tb_robotTop;
    timeunit 1ns;
    timeprecision 1ps;

    // cycles with the car switched off before the first test step
    localparam int startupHold = 20;

    logic        clk;
    logic        rst;
    logic [15:0] sw;
    logic        leftTrack;
    logic        midTrack;
    logic        rightTrack;
    logic [15:0] led;
    logic [3:0]  digit;
    logic [6:0]  segments;
    logic        in1, in2, in3, in4;
    logic        leftPwm, rightPwm;

    int          tbErrors = 0;
    int          stepEnable [$];
    string       stepTrack [$];
    int          stepHold [$];
    string       stepName [$];

    robotTop #(
        .COUNT_TICKS(12), .STOP_TICKS(30), .BLINK_TICKS(4),
        .LAMP_TICKS(4), .SCAN_TICKS(2), .PWM_PERIOD(4)
    ) dut_i (
        .clk(clk), .rst(rst), .sw(sw),
        .leftTrack(leftTrack), .midTrack(midTrack), .rightTrack(rightTrack),
        .led(led), .digit(digit), .segments(segments),
        .in1(in1), .in2(in2), .in3(in3), .in4(in4),
        .leftPwm(leftPwm), .rightPwm(rightPwm)
    );

    robotChecker checker_i (
        .clk(clk), .rst(rst), .led(led), .digit(digit), .segments(segments),
        .in1(in1), .in2(in2), .in3(in3), .in4(in4),
        .leftPwm(leftPwm), .rightPwm(rightPwm)
    );

    always #10 clk = ~clk;

    task automatic loadTests();
        int    fd;
        int    en;
        int    hold;
        string line;
        string trackStr;
        string name;
        fd = $fopen("robotTests.txt", "r");
        if (fd == 0) begin
            tbErrors++;
            $display("could not open robotTests.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %s %d %s", en, trackStr, hold, name) == 4) begin
                    stepEnable.push_back(en);
                    stepTrack.push_back(trackStr);
                    stepHold.push_back(hold);
                    stepName.push_back(name);
                end
            end
        end
        $fclose(fd);
    endtask

    // rnd means any code that keeps the car on the straight
    function automatic logic [2:0] trackCode(input string s);
        logic [2:0] code;
        logic [2:0] straightCodes [3];
        straightCodes = '{3'b010, 3'b011, 3'b110};
        code = 3'b000;
        if (s == "rnd") begin
            code = straightCodes[$urandom % 3];
        end else begin
            void'($sscanf(s, "%b", code));
        end
        return code;
    endfunction

    initial begin
        longint     totalCycles;
        logic [2:0] track;
        clk        = 1'b0;
        rst        = 1'b1;
        sw         = 16'h0000;
        leftTrack  = 1'b0;
        midTrack   = 1'b0;
        rightTrack = 1'b0;
        void'($urandom(56));
        loadTests();
        totalCycles = 16 + startupHold;
        foreach (stepHold[i]) begin
            totalCycles += stepHold[i];
        end

        fork
            begin
                #(totalCycles * 2 * 20);
                $display("timeout: the test steps did not complete in the expected time");
                $display("Errors found");
                $finish;
            end
        join_none

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle display and quiet motors right after reset
        repeat (startupHold) @(negedge clk);
        checker_i.checkState("idle", 3'b000);

        foreach (stepHold[i]) begin
            track = trackCode(stepTrack[i]);
            sw[0] = stepEnable[i][0];
            {leftTrack, midTrack, rightTrack} = track;
            repeat (stepHold[i]) @(negedge clk);
            checker_i.checkState(stepName[i], track);
        end

        $display("checks %0d, checker errors %0d, testbench errors %0d",
                 checker_i.checkCount, checker_i.errorCount, tbErrors);
        if (checker_i.errorCount == 0 && tbErrors == 0 && stepHold.size() > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: robotChecker.sv
module robotChecker (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] led,
    input  logic [3:0]  digit,
    input  logic [6:0]  segments,
    input  logic        in1,
    input  logic        in2,
    input  logic        in3,
    input  logic        in4,
    input  logic        leftPwm,
    input  logic        rightPwm
);
    timeunit 1ns;
    timeprecision 1ps;

    // active low, g f e d c b a, indexed by glyph code
    localparam logic [6:0] segPatterns [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h46, 7'h3F, 7'h4F, 7'h21, 7'h47, 7'h7F
    };

    int         errorCount = 0;
    int         checkCount = 0;
    logic [6:0] shown [4];
    logic [7:0] leftHist;
    logic [7:0] rightHist;
    logic [7:0] blinkHist;
    logic       countPending = 1'b0;
    logic [6:0] countSeq [$];

    // latest pattern per digit position, last eight PWM and blink samples
    always @(posedge clk) begin
        if (rst) begin
            leftHist  <= 8'h00;
            rightHist <= 8'h00;
            blinkHist <= 8'h00;
        end else begin
            leftHist  <= {leftHist[6:0], leftPwm};
            rightHist <= {rightHist[6:0], rightPwm};
            blinkHist <= {blinkHist[6:0], led[4]};
            case (digit)
                4'b0111: shown[0] <= segments;
                4'b1011: shown[1] <= segments;
                4'b1101: shown[2] <= segments;
                4'b1110: shown[3] <= segments;
                default: ;
            endcase
            if (led[15:11] == 5'b00001) begin
                countSeq.delete();
            end else if (led[15:11] == 5'b00010 && digit == 4'b1110) begin
                if (countSeq.size() == 0 || countSeq[$] != segments) begin
                    countSeq.push_back(segments);
                end
            end
        end
    end

    task automatic compare(input string sig, input int expVal, input int actVal);
        if (expVal != actVal) begin
            errorCount++;
            $display("FAIL t=%0t %s expected %0h got %0h", $time, sig, expVal, actVal);
        end
    endtask

    function automatic logic [4:0] statePattern(input string name);
        case (name)
            "idle":                                return 5'b00000;
            "countdown":                           return 5'b00010;
            "straight", "littleLeft", "littleRight": return 5'b01000;
            "left":                                return 5'b10000;
            "right":                               return 5'b00100;
            "stop":                                return 5'b11100;
            "back":                                return 5'b01010;
            "error":                               return 5'b11111;
            default:                               return 5'b00001;
        endcase
    endfunction

    function automatic logic [5:0] motionPattern(input string name);
        case (name)
            "straight", "littleLeft", "littleRight": return 6'b001100;
            "left":                                return 6'b110000;
            "right":                               return 6'b000011;
            "stop":                                return 6'b111111;
            default:                               return 6'b000000;
        endcase
    endfunction

    // in1 in2 in3 in4
    function automatic logic [3:0] pinPattern(input string name);
        case (name)
            "straight", "littleLeft", "littleRight", "choose": return 4'b1010;
            "left":  return 4'b0110;
            "right": return 4'b1001;
            "back":  return 4'b0101;
            default: return 4'b0000;
        endcase
    endfunction

    // -1 skips the position, -2 stands for the checkpoint digit
    function automatic int glyphAt(input string name, input int pos);
        int turnNum;
        turnNum = 0;
        case (name)
            "idle":      return (pos == 0) ? 1 : 11 + pos;
            "countdown": return (pos < 3) ? 11 : -1;
            "stop", "back": return 0;
            "error":     return 15;
            "choose":    turnNum = 1;
            "left":      turnNum = 3;
            "right":     turnNum = 4;
            "straight", "littleLeft", "littleRight": turnNum = 2;
            default:     return 11;
        endcase
        case (pos)
            0:       return 10;
            1:       return turnNum;
            2:       return 11;
            default: return -2;
        endcase
    endfunction

    task automatic checkState(input string name, input logic [2:0] track);
        int   expGlyph;
        int   leftExp;
        int   rightExp;
        logic moving;
        checkCount++;
        if (name == "choose") begin
            compare("led[12:11]", 0, led[12:11]);
            if (!$onehot(led[15:13])) begin
                errorCount++;
                $display("choose lamp at %0t is not one-hot: %b", $time, led[15:13]);
            end
        end else begin
            compare("led[15:11]", statePattern(name), led[15:11]);
        end
        compare("led[10]", 0, led[10]);
        compare("led[3]", 0, led[3]);
        // motion blinks in countdown and back, lit half the time
        if (name == "countdown" || name == "back") begin
            if (led[9:4] != 6'b000000 && led[9:4] != 6'b111111) begin
                errorCount++;
                $display("motion field at %0t is neither all on nor all off: %b",
                         $time, led[9:4]);
            end
            compare("led[4] blink duty", 4, $countones(blinkHist));
        end else begin
            compare("led[9:4]", motionPattern(name), led[9:4]);
        end
        compare("led[2:0]", track, led[2:0]);
        compare("in1..in4", pinPattern(name), {in1, in2, in3, in4});

        moving   = (pinPattern(name) != 4'b0000);
        leftExp  = moving ? ((name == "littleLeft") ? 4 : 8) : 0;
        rightExp = moving ? ((name == "littleRight") ? 4 : 8) : 0;
        compare("leftPwm duty", leftExp, $countones(leftHist));
        compare("rightPwm duty", rightExp, $countones(rightHist));

        for (int pos = 0; pos < 4; pos++) begin
            expGlyph = glyphAt(name, pos);
            // a held cross never lets a turning state set its checkpoint
            if (expGlyph == -2) begin
                expGlyph = (track != 3'b111) ? 1 : 0;
            end
            if (expGlyph >= 0) begin
                compare($sformatf("segments[%0d]", pos), segPatterns[expGlyph], shown[pos]);
            end
        end

        // countdown digits must have run 3, 2, 1
        if (name == "countdown") begin
            countPending = 1'b1;
        end else if (name == "straight" && countPending) begin
            countPending = 1'b0;
            if (countSeq.size() != 3) begin
                errorCount++;
                $display("countdown showed %0d distinct digits instead of 3", countSeq.size());
            end else begin
                compare("countdown digit 0", segPatterns[3], countSeq[0]);
                compare("countdown digit 1", segPatterns[2], countSeq[1]);
                compare("countdown digit 2", segPatterns[1], countSeq[2]);
            end
            countSeq.delete();
        end
    endtask

endmodule

// File: robotTop.sv
module robotTop import robotPkg::*; #(
    // board clock of 100 MHz
    parameter int COUNT_TICKS = 100_000_000,
    parameter int STOP_TICKS  = 50_000_000,
    parameter int BLINK_TICKS = 25_000_000,
    parameter int LAMP_TICKS  = 30_000_000,
    parameter int SCAN_TICKS  = 100_000,
    parameter int PWM_PERIOD  = 1_000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [15:0]         sw,
    input  logic                leftTrack,
    input  logic                midTrack,
    input  logic                rightTrack,
    output logic [ledWidth-1:0] led,
    output logic [3:0]          digit,
    output logic [6:0]          segments,
    output logic                in1,
    output logic                in2,
    output logic                in3,
    output logic                in4,
    output logic                leftPwm,
    output logic                rightPwm
);

    navState_t  state;
    roadCode_t  road;
    logic       checkpoint;
    logic       countEn, stopEn, blinkEn;
    logic [1:0] countStep;
    logic       countDone, stopDone, blinkPhase;

    assign countEn = (state == navCountdown);
    assign stopEn  = (state == navStop);
    assign blinkEn = (state == navCountdown) || (state == navBack);

    navFsm nav_i (
        .clk(clk), .rst(rst), .enable(sw[0]),
        .leftTrack(leftTrack), .midTrack(midTrack), .rightTrack(rightTrack),
        .countDone(countDone), .stopDone(stopDone),
        .state(state), .road(road), .checkpoint(checkpoint)
    );

    // countdown runs three steps, shown as 3, 2, 1
    phaseTimer #(.PERIOD(COUNT_TICKS), .STEPS(3)) countTimer (
        .clk(clk), .rst(rst), .enable(countEn),
        .phase(), .step(countStep), .done(countDone)
    );

    phaseTimer #(.PERIOD(STOP_TICKS), .STEPS(1)) stopTimer (
        .clk(clk), .rst(rst), .enable(stopEn),
        .phase(), .step(), .done(stopDone)
    );

    phaseTimer #(.PERIOD(BLINK_TICKS), .STEPS(2)) blinkTimer (
        .clk(clk), .rst(rst), .enable(blinkEn),
        .phase(blinkPhase), .step(), .done()
    );

    statusLeds #(.LAMP_TICKS(LAMP_TICKS)) leds_i (
        .clk(clk), .rst(rst), .state(state), .road(road), .blink(blinkPhase), .led(led)
    );

    digitDisplay #(.SCAN_TICKS(SCAN_TICKS)) display_i (
        .clk(clk), .rst(rst), .state(state), .countStep(countStep),
        .checkpoint(checkpoint), .digit(digit), .segments(segments)
    );

    motorDrive #(.PWM_PERIOD(PWM_PERIOD)) motor_i (
        .clk(clk), .rst(rst), .state(state),
        .in1(in1), .in2(in2), .in3(in3), .in4(in4),
        .leftPwm(leftPwm), .rightPwm(rightPwm)
    );

endmodule

// File: motorDrive.sv
module motorDrive import robotPkg::*; #(
    parameter int PWM_PERIOD = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  navState_t state,
    output logic      in1,
    output logic      in2,
    output logic      in3,
    output logic      in4,
    output logic      leftPwm,
    output logic      rightPwm
);

    localparam int CW = $clog2(PWM_PERIOD + 1);

    logic [CW-1:0] pwmCount;
    logic          moving;
    logic          firstHalf;

    // forward {1,3}, pivot left {2,3}, pivot right {1,4}, reverse {2,4}
    always_comb begin
        {in1, in2, in3, in4} = 4'b0000;
        case (state)
            navStraight, navLittleLeft, navLittleRight, navChoose: {in1, in3} = 2'b11;
            navLeft:  {in2, in3} = 2'b11;
            navRight: {in1, in4} = 2'b11;
            navBack:  {in2, in4} = 2'b11;
            default:  {in1, in2, in3, in4} = 4'b0000;
        endcase
    end

    assign moving    = in1 | in2 | in3 | in4;
    assign firstHalf = (pwmCount < CW'(PWM_PERIOD / 2));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwmCount <= '0;
            leftPwm  <= 1'b0;
            rightPwm <= 1'b0;
        end else begin
            pwmCount <= (pwmCount == CW'(PWM_PERIOD - 1)) ? '0 : pwmCount + 1'b1;
            // corrections slow the inner wheel to half duty
            leftPwm  <= moving && (state != navLittleLeft || firstHalf);
            rightPwm <= moving && (state != navLittleRight || firstHalf);
        end
    end

endmodule

// File: digitDisplay.sv
module digitDisplay import robotPkg::*; #(
    parameter int SCAN_TICKS = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  navState_t  state,
    input  logic [1:0] countStep,
    input  logic       checkpoint,
    output logic [3:0] digit,
    output logic [6:0] segments
);

    localparam int CW = $clog2(SCAN_TICKS + 1);

    logic [CW-1:0] scanCount;
    logic [1:0]    scanIdx;
    logic          scanning;
    glyph_t        glyphs [4];

    // glyphs[0] is the leftmost digit
    always_comb begin
        glyphs = '{glyphBlank, glyphBlank, glyphBlank, glyphBlank};
        case (state)
            navIdle:      glyphs = '{4'd1, glyphI, glyphD, glyphL};
            navStart:     glyphs = '{glyphDash, glyphDash, glyphDash, glyphDash};
            navCountdown: glyphs = '{glyphDash, glyphDash, glyphDash, 4'd3 - {2'b00, countStep}};
            navStraight, navLittleLeft, navLittleRight: begin
                glyphs = '{glyphC, 4'd2, glyphDash, {3'b000, checkpoint}};
            end
            navChoose: glyphs = '{glyphC, 4'd1, glyphDash, {3'b000, checkpoint}};
            navLeft:   glyphs = '{glyphC, 4'd3, glyphDash, {3'b000, checkpoint}};
            navRight:  glyphs = '{glyphC, 4'd4, glyphDash, {3'b000, checkpoint}};
            navStop, navBack: glyphs = '{4'd0, 4'd0, 4'd0, 4'd0};
            default:   glyphs = '{glyphBlank, glyphBlank, glyphBlank, glyphBlank};
        endcase
    end

    // first scan tick only switches the display on
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanCount <= '0;
            scanIdx   <= 2'd0;
            scanning  <= 1'b0;
        end else if (scanCount == CW'(SCAN_TICKS - 1)) begin
            scanCount <= '0;
            if (scanning) begin
                scanIdx <= scanIdx + 2'd1;
            end else begin
                scanning <= 1'b1;
            end
        end else begin
            scanCount <= scanCount + 1'b1;
        end
    end

    // active-low select, digit[3] is the leftmost
    assign digit    = scanning ? ~(4'b1000 >> scanIdx) : 4'b1111;
    assign segments = SEG_TABLE[glyphs[scanIdx]];

endmodule

// File: statusLeds.sv
module statusLeds import robotPkg::*; #(
    parameter int LAMP_TICKS = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  navState_t           state,
    input  roadCode_t           road,
    input  logic                blink,
    output logic [ledWidth-1:0] led
);

    localparam int CW = $clog2(LAMP_TICKS + 1);

    logic [CW-1:0] lampCount;
    logic [2:0]    lamp;
    logic [4:0]    statePat;
    logic [5:0]    motion;

    // one-hot lamp walks while choosing, parks at 001 otherwise
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (state != navChoose) begin
            lampCount <= '0;
            lamp      <= 3'b001;
        end else if (lampCount == CW'(LAMP_TICKS - 1)) begin
            lampCount <= '0;
            lamp      <= {lamp[1:0], lamp[2]};
        end else begin
            lampCount <= lampCount + 1'b1;
        end
    end

    always_comb begin
        statePat = 5'b00000;
        motion   = 6'b000000;
        case (state)
            navStart:     statePat = 5'b00001;
            navCountdown: begin
                statePat = 5'b00010;
                motion   = blink ? 6'b000000 : 6'b111111;
            end
            navStraight, navLittleLeft, navLittleRight: begin
                statePat = 5'b01000;
                motion   = 6'b001100;
            end
            navChoose: statePat = {lamp, 2'b00};
            navLeft: begin
                statePat = 5'b10000;
                motion   = 6'b110000;
            end
            navRight: begin
                statePat = 5'b00100;
                motion   = 6'b000011;
            end
            navStop: begin
                statePat = 5'b11100;
                motion   = 6'b111111;
            end
            navBack: begin
                statePat = 5'b01010;
                motion   = blink ? 6'b000000 : 6'b111111;
            end
            navError: statePat = 5'b11111;
            default:  statePat = 5'b00000;
        endcase
    end

    // state, gap, motion, gap, road
    assign led = {statePat, 1'b0, motion, 1'b0, road};

endmodule

// File: phaseTimer.sv
module phaseTimer #(
    parameter int PERIOD = 4,
    parameter int STEPS  = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    output logic       phase,
    output logic [1:0] step,
    output logic       done
);

    localparam int CW = $clog2(PERIOD + 1);

    logic [CW-1:0] count;
    logic          periodEnd;

    // PERIOD of two or more keeps done quiet while cleared
    assign periodEnd = (count == CW'(PERIOD - 1));
    assign done      = periodEnd && (step == 2'(STEPS - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
            phase <= 1'b0;
            step  <= 2'd0;
        end else if (!enable) begin
            count <= '0;
            phase <= 1'b0;
            step  <= 2'd0;
        end else if (periodEnd) begin
            count <= '0;
            phase <= ~phase;
            step  <= done ? 2'd0 : step + 2'd1;
        end else begin
            count <= count + 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) !enable |-> !done)
        else $error("phaseTimer: done while disabled");

endmodule

// File: navFsm.sv
module navFsm import robotPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      enable,
    input  logic      leftTrack,
    input  logic      midTrack,
    input  logic      rightTrack,
    input  logic      countDone,
    input  logic      stopDone,
    output navState_t state,
    output roadCode_t road,
    output logic      checkpoint
);

    logic [2:0] syncA;
    logic [2:0] syncB;
    navState_t  nextState;
    navState_t  resumeState;
    navState_t  nextResume;
    logic [1:0] crossCount;
    logic       crossDone;

    // little-left and little-right share the straight checkpoint
    function automatic navState_t groupOf(navState_t s);
        if (s == navLittleLeft || s == navLittleRight) begin
            return navStraight;
        end
        return s;
    endfunction

    function automatic logic isTurning(navState_t s);
        return groupOf(s) inside {navStraight, navChoose, navLeft, navRight};
    endfunction

    // two sync flops, then the road register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncA <= 3'b000;
            syncB <= 3'b000;
            road  <= roadLost;
        end else begin
            syncA <= {leftTrack, midTrack, rightTrack};
            syncB <= syncA;
            road  <= roadCode_t'(syncB);
        end
    end

    assign crossDone = (crossCount == 2'd3);

    always_comb begin
        nextState  = state;
        nextResume = resumeState;
        case (state)
            navIdle: begin
                if (enable) begin
                    nextState = navStart;
                end
            end
            navStart: begin
                if (road == roadStraight) begin
                    nextState = navCountdown;
                end
            end
            navCountdown: begin
                if (countDone) begin
                    nextState = navStraight;
                end
            end
            navStraight, navLittleLeft, navLittleRight: begin
                case (road)
                    roadLost: begin
                        nextState  = navStop;
                        nextResume = navBack;
                    end
                    roadCross:       nextState = checkpoint ? navChoose : navStraight;
                    roadLittleRight: nextState = navLittleRight;
                    roadLittleLeft:  nextState = navLittleLeft;
                    default:         nextState = navStraight;
                endcase
            end
            navChoose: begin
                if (road == roadFork) begin
                    nextState  = navStop;
                    nextResume = navLeft;
                end else if (road == roadCross && checkpoint) begin
                    nextState = navStraight;
                end
            end
            navLeft: begin
                if (road == roadFork) begin
                    nextState  = navStop;
                    nextResume = navRight;
                end else if (road == roadCross && checkpoint) begin
                    nextState  = navStop;
                    nextResume = navStraight;
                end
            end
            navRight: begin
                if (road == roadCross && checkpoint && crossDone) begin
                    nextState  = navStop;
                    nextResume = navStraight;
                end else if (road == roadFork && crossDone) begin
                    nextState = navError;
                end
            end
            navBack: begin
                // no turn history, so back always resumes left
                if (road == roadCross) begin
                    nextState  = navStop;
                    nextResume = navLeft;
                end
            end
            navStop: begin
                if (stopDone) begin
                    nextState = resumeState;
                end
            end
            default: nextState = state;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= navIdle;
            resumeState <= navIdle;
        end else if (!enable) begin
            state <= navIdle;
        end else begin
            state       <= nextState;
            resumeState <= nextResume;
        end
    end

    // cleared on leaving a state group, set by the first non-cross road
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            checkpoint <= 1'b0;
        end else if (!enable) begin
            checkpoint <= 1'b0;
        end else if (groupOf(nextState) != groupOf(state)) begin
            checkpoint <= (state == navCountdown);
        end else if (isTurning(state) && road != roadCross) begin
            checkpoint <= 1'b1;
        end
    end

    // cross samples seen during one right-turn visit, saturating
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crossCount <= 2'd0;
        end else if (state != navRight) begin
            crossCount <= 2'd0;
        end else if (road == roadCross && !crossDone) begin
            crossCount <= crossCount + 2'd1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) state inside {[navIdle:navError]})
        else $error("navFsm: undefined state encoding %0d", state);

    assert property (@(posedge clk) disable iff (rst)
        $rose(state == navStop) |-> resumeState inside {navStraight, navLeft, navRight, navBack})
        else $error("navFsm: stop entered with resume state %0d", resumeState);

endmodule

// File: robotPkg.sv
package robotPkg;

    // navigation states, straight keeps its two correction variants
    typedef enum logic [3:0] {
        navIdle        = 4'd0,
        navStart       = 4'd1,
        navCountdown   = 4'd2,
        navStraight    = 4'd3,
        navLittleLeft  = 4'd4,
        navLittleRight = 4'd5,
        navChoose      = 4'd6,
        navLeft        = 4'd7,
        navRight       = 4'd8,
        navBack        = 4'd9,
        navStop        = 4'd10,
        navError       = 4'd11
    } navState_t;

    // sensor bits are left, middle, right
    typedef enum logic [2:0] {
        roadLost        = 3'b000,
        roadLittleRight = 3'b001,
        roadStraight    = 3'b010,
        roadRight       = 3'b011,
        roadLittleLeft  = 3'b100,
        roadFork        = 3'b101,
        roadLeft        = 3'b110,
        roadCross       = 3'b111
    } roadCode_t;

    // 0 to 9 are numerals
    typedef logic [3:0] glyph_t;

    localparam glyph_t glyphC     = 4'd10;
    localparam glyph_t glyphDash  = 4'd11;
    localparam glyph_t glyphI     = 4'd12;
    localparam glyph_t glyphD     = 4'd13;
    localparam glyph_t glyphL     = 4'd14;
    localparam glyph_t glyphBlank = 4'd15;

    localparam int ledWidth = 16;

    // active low, bit order g f e d c b a
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h46, 7'h3F, 7'h4F, 7'h21, 7'h47, 7'h7F
    };

endpackage
